// ==== logic/hcore_pkg.sv ====
package hcore_pkg;

	// Architectural and datapath widths
	localparam int XLEN  = 32;
	localparam int HLEN  = 16;
	localparam int NREGS = 32;

	// Accepted major opcodes
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;

	// funct3 codes for the supported ALU operations
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// funct7 that turns ADD into SUB
	localparam logic [6:0] F7_SUB = 7'b0100000;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS_B
	} alu_op_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_type_t;

	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_type_t;

	typedef struct packed {
		logic [19:0] imm20;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_type_t;

	// Same instruction word, three field layouts
	typedef union packed {
		r_type_t r;
		i_type_t i;
		u_type_t u;
	} instr_u;

endpackage

// ==== logic/decode_stage.sv ====
module decode_stage (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         issue_i,
	input  logic [hcore_pkg::XLEN-1:0]   instr_i,
	input  logic [hcore_pkg::HLEN-1:0]   rs1_half_i,
	input  logic [hcore_pkg::HLEN-1:0]   rs2_half_i,
	output logic [4:0]                   rs1_addr_o,
	output logic [4:0]                   rs2_addr_o,
	output logic                         rd_half_sel_o,
	output logic [hcore_pkg::HLEN-1:0]   op_a_half_o,
	output logic [hcore_pkg::HLEN-1:0]   op_b_half_o,
	output hcore_pkg::alu_op_e           alu_op_o,
	output logic                         hi_half_o,
	output logic                         ex_valid_o,
	output logic                         wr_en_o,
	output logic [4:0]                   rd_o,
	output logic                         illegal_o
);
	import hcore_pkg::*;

	instr_u          ins;
	logic [XLEN-1:0] instr_q;
	logic [XLEN-1:0] imm;
	logic [HLEN-1:0] imm_half;
	logic            pend;
	logic            phase;
	logic            legal;
	logic            is_imm;
	logic            is_lui;
	alu_op_e         op;

	assign ins = instr_q;

	// Register file read addresses come straight from the held word
	assign rs1_addr_o    = ins.r.rs1;
	assign rs2_addr_o    = ins.r.rs2;
	assign rd_half_sel_o = phase;

	always_comb begin
		legal  = 1'b0;
		is_imm = 1'b0;
		is_lui = 1'b0;
		op     = ALU_ADD;
		case (ins.r.opcode)
			OPC_OP: begin
				case (ins.r.funct3)
					F3_ADD_SUB: begin
						if (ins.r.funct7 == '0) begin
							legal = 1'b1;
						end else if (ins.r.funct7 == F7_SUB) begin
							legal = 1'b1;
							op    = ALU_SUB;
						end
					end
					F3_XOR: begin
						legal = (ins.r.funct7 == '0);
						op    = ALU_XOR;
					end
					F3_OR: begin
						legal = (ins.r.funct7 == '0);
						op    = ALU_OR;
					end
					F3_AND: begin
						legal = (ins.r.funct7 == '0);
						op    = ALU_AND;
					end
					default: legal = 1'b0;
				endcase
			end
			OPC_OP_IMM: begin
				is_imm = 1'b1;
				case (ins.i.funct3)
					F3_ADD_SUB: legal = 1'b1;
					F3_XOR: begin
						legal = 1'b1;
						op    = ALU_XOR;
					end
					F3_OR: begin
						legal = 1'b1;
						op    = ALU_OR;
					end
					F3_AND: begin
						legal = 1'b1;
						op    = ALU_AND;
					end
					default: legal = 1'b0;
				endcase
			end
			OPC_LUI: begin
				legal  = 1'b1;
				is_imm = 1'b1;
				is_lui = 1'b1;
				op     = ALU_PASS_B;
			end
			default: legal = 1'b0;
		endcase
	end

	// U immediate sits in the top bits and I immediate is sign extended
	assign imm      = is_lui ? {ins.u.imm20, 12'b0}
	                         : {{(XLEN-12){ins.i.imm12[11]}}, ins.i.imm12};
	assign imm_half = phase ? imm[XLEN-1:HLEN] : imm[HLEN-1:0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pend       <= 1'b0;
			phase      <= 1'b0;
			ex_valid_o <= 1'b0;
			hi_half_o  <= 1'b0;
			wr_en_o    <= 1'b0;
			illegal_o  <= 1'b0;
		end else begin
			ex_valid_o <= pend && legal;
			hi_half_o  <= pend && legal && phase;
			wr_en_o    <= pend && legal;
			illegal_o  <= pend && !phase && !legal;
			if (issue_i) begin
				pend  <= 1'b1;
				phase <= 1'b0;
			end else if (pend && !phase && legal) begin
				phase <= 1'b1;
			end else begin
				pend  <= 1'b0;
				phase <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (issue_i) begin
			instr_q <= instr_i;
		end
		op_a_half_o <= is_lui ? '0 : rs1_half_i;
		op_b_half_o <= is_imm ? imm_half : rs2_half_i;
		alu_op_o    <= op;
		rd_o        <= ins.r.rd;
	end

	a_issue_spacing: assert property (@(posedge clk) disable iff (!rst_n)
		issue_i |=> !issue_i);

	// Each valid lower half is followed by its upper half
	a_lo_then_hi: assert property (@(posedge clk) disable iff (!rst_n)
		ex_valid_o && !hi_half_o |=> ex_valid_o && hi_half_o);

endmodule

// ==== logic/half_alu.sv ====
module half_alu (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       ex_valid_i,
	input  logic                       hi_half_i,
	input  logic [hcore_pkg::HLEN-1:0] op_a_i,
	input  logic [hcore_pkg::HLEN-1:0] op_b_i,
	input  hcore_pkg::alu_op_e         alu_op_i,
	output logic [hcore_pkg::HLEN-1:0] res_half_o
);
	import hcore_pkg::*;

	logic [HLEN-1:0] b_eff;
	logic [HLEN:0]   sum;
	logic            cin;
	logic            carry_q;

	// Subtract as A + ~B + 1, the +1 enters on the lower half only
	assign b_eff = (alu_op_i == ALU_SUB) ? ~op_b_i : op_b_i;
	assign cin   = hi_half_i ? carry_q : (alu_op_i == ALU_SUB);
	assign sum   = {1'b0, op_a_i} + {1'b0, b_eff} + {{HLEN{1'b0}}, cin};

	always_comb begin
		case (alu_op_i)
			ALU_ADD,
			ALU_SUB:    res_half_o = sum[HLEN-1:0];
			ALU_AND:    res_half_o = op_a_i & op_b_i;
			ALU_OR:     res_half_o = op_a_i | op_b_i;
			ALU_XOR:    res_half_o = op_a_i ^ op_b_i;
			ALU_PASS_B: res_half_o = op_b_i;
			default:    res_half_o = '0;
		endcase
	end

	// Carry out of bit 15 for the upper half
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			carry_q <= 1'b0;
		end else if (ex_valid_i && !hi_half_i) begin
			carry_q <= sum[HLEN];
		end
	end

	a_hi_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
		hi_half_i |-> ex_valid_i);

endmodule

// ==== logic/result_stage.sv ====
module result_stage (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic [4:0]                 rs1_addr_i,
	input  logic [4:0]                 rs2_addr_i,
	input  logic                       rd_half_sel_i,
	output logic [hcore_pkg::HLEN-1:0] rs1_half_o,
	output logic [hcore_pkg::HLEN-1:0] rs2_half_o,
	input  logic                       ex_valid_i,
	input  logic                       hi_half_i,
	input  logic                       wr_en_i,
	input  logic [4:0]                 rd_i,
	input  logic [hcore_pkg::HLEN-1:0] res_half_i,
	output logic                       wb_valid_o,
	output logic [4:0]                 wb_rd_o,
	output logic [hcore_pkg::XLEN-1:0] wb_data_o
);
	import hcore_pkg::*;

	logic [XLEN-1:0] rf [NREGS];
	logic [XLEN-1:0] rs1_word;
	logic [XLEN-1:0] rs2_word;
	logic [HLEN-1:0] lo_q;

	assign rs1_word = rf[rs1_addr_i];
	assign rs2_word = rf[rs2_addr_i];

	// Half selected by the decode phase
	assign rs1_half_o = rd_half_sel_i ? rs1_word[XLEN-1:HLEN] : rs1_word[HLEN-1:0];
	assign rs2_half_o = rd_half_sel_i ? rs2_word[XLEN-1:HLEN] : rs2_word[HLEN-1:0];

	// One half per cycle, x0 stays zero
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int k = 0; k < NREGS; k++) begin
				rf[k] <= '0;
			end
		end else if (ex_valid_i && wr_en_i && rd_i != '0) begin
			if (hi_half_i) begin
				rf[rd_i][XLEN-1:HLEN] <= res_half_i;
			end else begin
				rf[rd_i][HLEN-1:0] <= res_half_i;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid_o <= 1'b0;
		end else begin
			wb_valid_o <= ex_valid_i && wr_en_i && hi_half_i;
		end
	end

	// Lower half kept to report the full word with the upper one
	always_ff @(posedge clk) begin
		if (ex_valid_i && !hi_half_i) begin
			lo_q <= res_half_i;
		end
		if (ex_valid_i && hi_half_i) begin
			wb_rd_o   <= rd_i;
			wb_data_o <= {res_half_i, lo_q};
		end
	end

	a_write_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en_i |-> ex_valid_i);

	// Upper write completes the lower write of the same register
	a_hi_write_pairs: assert property (@(posedge clk) disable iff (!rst_n)
		ex_valid_i && wr_en_i && hi_half_i
		|-> $past(ex_valid_i && wr_en_i && !hi_half_i) && $past(rd_i) == rd_i);

endmodule

// ==== logic/half_core_top.sv ====
module half_core_top (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       issue_i,
	input  logic [hcore_pkg::XLEN-1:0] instr_i,
	output logic                       wb_valid_o,
	output logic [4:0]                 wb_rd_o,
	output logic [hcore_pkg::XLEN-1:0] wb_data_o,
	output logic                       illegal_o
);
	import hcore_pkg::*;

	logic [4:0]      rs1_addr;
	logic [4:0]      rs2_addr;
	logic            rd_half_sel;
	logic [HLEN-1:0] rs1_half;
	logic [HLEN-1:0] rs2_half;
	logic [HLEN-1:0] op_a_half;
	logic [HLEN-1:0] op_b_half;
	alu_op_e         alu_op;
	logic            hi_half;
	logic            ex_valid;
	logic            wr_en;
	logic [4:0]      rd;
	logic [HLEN-1:0] res_half;

	decode_stage i_decode_stage (
		.clk           (clk),
		.rst_n         (rst_n),
		.issue_i       (issue_i),
		.instr_i       (instr_i),
		.rs1_half_i    (rs1_half),
		.rs2_half_i    (rs2_half),
		.rs1_addr_o    (rs1_addr),
		.rs2_addr_o    (rs2_addr),
		.rd_half_sel_o (rd_half_sel),
		.op_a_half_o   (op_a_half),
		.op_b_half_o   (op_b_half),
		.alu_op_o      (alu_op),
		.hi_half_o     (hi_half),
		.ex_valid_o    (ex_valid),
		.wr_en_o       (wr_en),
		.rd_o          (rd),
		.illegal_o     (illegal_o)
	);

	half_alu i_half_alu (
		.clk        (clk),
		.rst_n      (rst_n),
		.ex_valid_i (ex_valid),
		.hi_half_i  (hi_half),
		.op_a_i     (op_a_half),
		.op_b_i     (op_b_half),
		.alu_op_i   (alu_op),
		.res_half_o (res_half)
	);

	result_stage i_result_stage (
		.clk           (clk),
		.rst_n         (rst_n),
		.rs1_addr_i    (rs1_addr),
		.rs2_addr_i    (rs2_addr),
		.rd_half_sel_i (rd_half_sel),
		.rs1_half_o    (rs1_half),
		.rs2_half_o    (rs2_half),
		.ex_valid_i    (ex_valid),
		.hi_half_i     (hi_half),
		.wr_en_i       (wr_en),
		.rd_i          (rd),
		.res_half_i    (res_half),
		.wb_valid_o    (wb_valid_o),
		.wb_rd_o       (wb_rd_o),
		.wb_data_o     (wb_data_o)
	);

endmodule

// ==== tb/tb_half_core.sv ====
module tb_half_core;

	localparam int SEED         = 37;
	localparam int RESET_CYCLES = 8;
	localparam int N_ARITH      = 6;
	localparam int N_LOGIC      = 4;
	localparam int TOTAL_ISSUES = 8 + 6 * N_ARITH + 10 * N_LOGIC + 9 + 5 + 8;
	localparam int CYCLE_LIMIT  = TOTAL_ISSUES * 4 + 100;

	// RV32I encodings for the reference model and the stimulus
	localparam logic [6:0] OPC_REG    = 7'b0110011;
	localparam logic [6:0] OPC_IMM    = 7'b0010011;
	localparam logic [6:0] OPC_UPPER  = 7'b0110111;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [2:0] F3_ADD     = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;
	localparam logic [6:0] F7_BASE    = 7'b0000000;
	localparam logic [6:0] F7_ALT     = 7'b0100000;
	localparam logic [6:0] F7_MULDIV  = 7'b0000001;

	logic        clk;
	logic        rst_n;
	logic        issue;
	logic [31:0] instr;
	logic        wb_valid;
	logic [4:0]  wb_rd;
	logic [31:0] wb_data;
	logic        illegal;

	logic [31:0] ref_regs [32];
	logic [31:0] prog [$];
	logic [31:0] rng;
	int          errors;
	int          checks;
	int          cycles;

	half_core_top i_half_core_top (
		.clk        (clk),
		.rst_n      (rst_n),
		.issue_i    (issue),
		.instr_i    (instr),
		.wb_valid_o (wb_valid),
		.wb_rd_o    (wb_rd),
		.wb_data_o  (wb_data),
		.illegal_o  (illegal)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OPC_REG};
	endfunction

	function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] u_word(input logic [19:0] imm20, input logic [4:0] rd);
		return {imm20, rd, OPC_UPPER};
	endfunction

	// LUI then ADDI, upper part rounded up since ADDI sign extends
	task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
		logic [31:0] rounded;
		rounded = value + 32'h0000_0800;
		prog.push_back(u_word(rounded[31:12], rd));
		prog.push_back(i_word(value[11:0], rd, F3_ADD, rd, OPC_IMM));
	endtask

	// RV32 semantics for the subset, x0 stays zero
	task automatic apply_model(input logic [31:0] ins, output logic ok,
			output logic [4:0] rd, output logic [31:0] res);
		logic [6:0]  f7;
		logic [2:0]  f3;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		f7  = ins[31:25];
		f3  = ins[14:12];
		rd  = ins[11:7];
		a   = ref_regs[ins[19:15]];
		b   = ref_regs[ins[24:20]];
		imm = {{20{ins[31]}}, ins[31:20]};
		ok  = 1'b1;
		res = '0;
		case (ins[6:0])
			OPC_REG: begin
				case ({f7, f3})
					{F7_BASE, F3_ADD}: res = a + b;
					{F7_ALT, F3_ADD}:  res = a - b;
					{F7_BASE, F3_XOR}: res = a ^ b;
					{F7_BASE, F3_OR}:  res = a | b;
					{F7_BASE, F3_AND}: res = a & b;
					default:           ok = 1'b0;
				endcase
			end
			OPC_IMM: begin
				case (f3)
					F3_ADD:  res = a + imm;
					F3_XOR:  res = a ^ imm;
					F3_OR:   res = a | imm;
					F3_AND:  res = a & imm;
					default: ok = 1'b0;
				endcase
			end
			OPC_UPPER: res = {ins[31:12], 12'h000};
			default:   ok = 1'b0;
		endcase
		if (ok && rd != 5'd0) begin
			ref_regs[rd] = res;
		end
	endtask

	// Issues the queued program every two cycles and checks each response
	task automatic run_program();
		logic        exp_ok [$];
		logic [4:0]  exp_rd [$];
		logic [31:0] exp_data [$];
		logic        ok;
		logic [4:0]  rd;
		logic [31:0] res;
		logic        exp_ill;
		logic        exp_wb;
		int          n;
		n = prog.size();
		for (int s = 0; s <= n + 1; s++) begin
			@(negedge clk);
			exp_ill = 1'b0;
			exp_wb  = 1'b0;
			// Illegal shows one cycle after issue, writeback three cycles after
			if (s >= 1 && s <= n) begin
				exp_ill = !exp_ok[s - 1];
			end
			if (s >= 2) begin
				exp_wb = exp_ok[s - 2];
			end
			checks += 2;
			if (illegal !== exp_ill) begin
				$display("ERROR illegal_o: got %h expected %h", illegal, exp_ill);
				errors++;
			end
			if (wb_valid !== exp_wb) begin
				$display("ERROR wb_valid_o: got %h expected %h", wb_valid, exp_wb);
				errors++;
			end
			if (exp_wb) begin
				checks += 2;
				if (wb_rd !== exp_rd[s - 2]) begin
					$display("ERROR wb_rd_o: got %h expected %h", wb_rd, exp_rd[s - 2]);
					errors++;
				end
				if (wb_data !== exp_data[s - 2]) begin
					$display("ERROR wb_data_o: got %h expected %h (instr %h)",
						wb_data, exp_data[s - 2], prog[s - 2]);
					errors++;
				end
			end
			if (s < n) begin
				apply_model(prog[s], ok, rd, res);
				exp_ok.push_back(ok);
				exp_rd.push_back(rd);
				exp_data.push_back(res);
				issue = 1'b1;
				instr = prog[s];
			end
			@(negedge clk);
			issue = 1'b0;
			checks += 2;
			if (wb_valid !== 1'b0) begin
				$display("ERROR wb_valid_o: got %h expected %h", wb_valid, 1'b0);
				errors++;
			end
			if (illegal !== 1'b0) begin
				$display("ERROR illegal_o: got %h expected %h", illegal, 1'b0);
				errors++;
			end
		end
		prog.delete();
	endtask

	task automatic check_loads();
		$display("Loads and immediates");
		load_reg(5'd1, 32'h1234_5678);
		prog.push_back(u_word(20'habcde, 5'd2));
		prog.push_back(i_word(12'h5a5, 5'd0, F3_OR, 5'd3, OPC_IMM));
		prog.push_back(i_word(12'hffd, 5'd0, F3_ADD, 5'd4, OPC_IMM));
		prog.push_back(i_word(12'h800, 5'd1, F3_ADD, 5'd5, OPC_IMM));
		load_reg(5'd6, 32'h0000_8fff);
		run_program();
	endtask

	task automatic arith_random();
		logic [31:0] a;
		logic [31:0] b;
		$display("ADD and SUB");
		for (int r = 0; r < N_ARITH; r++) begin
			rng = xorshift32(rng);
			// First two rounds force a carry and a borrow across bit 15
			a = (r == 0) ? 32'h0000_ffff : (r == 1) ? 32'h0001_0000 : rng;
			rng = xorshift32(rng);
			b = (r < 2) ? 32'h0000_0001 : rng;
			load_reg(5'd10, a);
			load_reg(5'd11, b);
			prog.push_back(r_word(F7_BASE, 5'd11, 5'd10, F3_ADD, 5'd12));
			prog.push_back(r_word(F7_ALT, 5'd11, 5'd10, F3_ADD, 5'd13));
		end
		run_program();
	endtask

	task automatic logic_ops();
		$display("Logic operations");
		for (int r = 0; r < N_LOGIC; r++) begin
			rng = xorshift32(rng);
			load_reg(5'd14, rng);
			rng = xorshift32(rng);
			load_reg(5'd15, rng);
			prog.push_back(r_word(F7_BASE, 5'd15, 5'd14, F3_AND, 5'd16));
			prog.push_back(r_word(F7_BASE, 5'd15, 5'd14, F3_OR, 5'd17));
			prog.push_back(r_word(F7_BASE, 5'd15, 5'd14, F3_XOR, 5'd18));
			rng = xorshift32(rng);
			prog.push_back(i_word(rng[11:0], 5'd14, F3_AND, 5'd19, OPC_IMM));
			prog.push_back(i_word(rng[23:12], 5'd14, F3_OR, 5'd20, OPC_IMM));
			prog.push_back(i_word(rng[31:20], 5'd15, F3_XOR, 5'd21, OPC_IMM));
		end
		run_program();
	endtask

	task automatic dependent_chain();
		$display("Dependent chain");
		load_reg(5'd22, 32'h7fff_8000);
		prog.push_back(r_word(F7_BASE, 5'd22, 5'd22, F3_ADD, 5'd22));
		prog.push_back(i_word(12'hfff, 5'd22, F3_ADD, 5'd22, OPC_IMM));
		prog.push_back(r_word(F7_BASE, 5'd22, 5'd22, F3_ADD, 5'd23));
		prog.push_back(r_word(F7_ALT, 5'd22, 5'd23, F3_ADD, 5'd22));
		prog.push_back(i_word(12'h7f0, 5'd22, F3_OR, 5'd22, OPC_IMM));
		prog.push_back(r_word(F7_BASE, 5'd23, 5'd22, F3_AND, 5'd24));
		prog.push_back(r_word(F7_BASE, 5'd22, 5'd24, F3_XOR, 5'd25));
		run_program();
	endtask

	task automatic zero_reg_writes();
		$display("Writes to x0");
		prog.push_back(i_word(12'h123, 5'd0, F3_ADD, 5'd0, OPC_IMM));
		prog.push_back(u_word(20'hfffff, 5'd0));
		prog.push_back(r_word(F7_BASE, 5'd0, 5'd0, F3_ADD, 5'd26));
		prog.push_back(r_word(F7_BASE, 5'd13, 5'd12, F3_ADD, 5'd0));
		prog.push_back(i_word(12'h7ff, 5'd0, F3_XOR, 5'd27, OPC_IMM));
		run_program();
	endtask

	task automatic illegal_opcode();
		$display("Illegal instructions");
		load_reg(5'd28, 32'hcafe_1234);
		prog.push_back(i_word(12'h004, 5'd0, 3'b010, 5'd28, OPC_LOAD));
		prog.push_back(r_word(F7_BASE, 5'd28, 5'd28, F3_SLL, 5'd28));
		prog.push_back(r_word(F7_MULDIV, 5'd28, 5'd28, F3_ADD, 5'd28));
		prog.push_back(i_word(12'h001, 5'd28, F3_SLL, 5'd28, OPC_IMM));
		prog.push_back(r_word(F7_ALT, 5'd28, 5'd28, F3_XOR, 5'd28));
		// Reads x28 back to show it kept its value
		prog.push_back(r_word(F7_BASE, 5'd0, 5'd28, F3_OR, 5'd29));
		run_program();
	endtask

	initial begin
		rst_n  = 1'b0;
		issue  = 1'b0;
		instr  = '0;
		errors = 0;
		checks = 0;
		rng    = SEED;
		for (int k = 0; k < 32; k++) begin
			ref_regs[k] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		check_loads();
		arith_random();
		logic_ops();
		dependent_chain();
		zero_reg_writes();
		illegal_opcode();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	// Watchdog sized from the number of issued instructions
	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Checks: %0d, errors: %0d", checks, errors);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== filelist.f ====
logic/hcore_pkg.sv
logic/decode_stage.sv
logic/half_alu.sv
logic/result_stage.sv
logic/half_core_top.sv
tb/tb_half_core.sv

// ==== Makefile ====
# Verilator flow for the half-word core testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_half_core
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= NO ERRORS

SRCS := $(shell cat $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Passes only when the pass message appears as a line of its own
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
